/* logic/lcd_bus_driver.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_bus_driver (
   input  logic                   resetn,
   input  logic                   clk,
   input  lcd_pkg::lcd_step_t     step,
   input  logic [`LCD_DATA_W-1:0] char_code,
   output lcd_pkg::lcd_bus_t      lcd
);

   localparam lcd_pkg::lcd_bus_t BUS_IDLE = '{rs: 1'b1, rw: 1'b1, data: '0};

   lcd_pkg::lcd_bus_t bus_nxt;

   always_comb begin
      bus_nxt.rs   = 1'b0; // command write by default
      bus_nxt.rw   = 1'b0;
      bus_nxt.data = '0;
      case (step.phase)
         lcd_pkg::ph_powerup: begin
            bus_nxt = BUS_IDLE;
         end
         lcd_pkg::ph_func_set: begin
            bus_nxt.data = `LCD_CMD_FUNC;
         end
         lcd_pkg::ph_disp_on: begin
            bus_nxt.data = `LCD_CMD_DISP_ON;
         end
         lcd_pkg::ph_entry_set, lcd_pkg::ph_entry_hold: begin
            bus_nxt.data = `LCD_CMD_ENTRY;
         end
         lcd_pkg::ph_home: begin
            bus_nxt.data = `LCD_CMD_HOME;
         end
         default: begin
            if (step.count == '0) begin
               bus_nxt.data = (step.phase == lcd_pkg::ph_line1) ? `LCD_ADDR_LINE1
                                                                 : `LCD_ADDR_LINE2;
            end else begin
               bus_nxt.rs   = 1'b1; // character write
               bus_nxt.data = char_code;
            end
         end
      endcase
   end

   always_ff @(posedge resetn or posedge clk) begin
      if (clk) lcd <= BUS_IDLE;
      else lcd <= bus_nxt;
   end

endmodule

/* logic/lcd_params.svh */
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// bus and counter widths
`define LCD_DATA_W 8
`define LCD_CNT_W 9
`define LCD_COLS 16

// last count of each phase
`define LCD_T_POWERUP 70
`define LCD_T_SETUP 30
`define LCD_T_LINE 20
`define LCD_T_HOME 400
`define LCD_T_ENTRY 200

// command and character codes
`define LCD_CMD_FUNC 8'h3C
`define LCD_CMD_DISP_ON 8'h0C
`define LCD_CMD_ENTRY 8'h06
`define LCD_CMD_HOME 8'h02
`define LCD_ADDR_LINE1 8'h80
`define LCD_ADDR_LINE2 8'hC0
`define LCD_CHAR_SPACE 8'h20

`endif

/* logic/lcd_pkg.sv */
`include "lcd_params.svh"

package lcd_pkg;

   // sequencer phases, in the order they run
   typedef enum logic [2:0] {
      ph_powerup    = 3'd0,
      ph_func_set   = 3'd1,
      ph_disp_on    = 3'd2,
      ph_entry_set  = 3'd3,
      ph_line1      = 3'd4,
      ph_line2      = 3'd5,
      ph_home       = 3'd6,
      ph_entry_hold = 3'd7
   } phase_t;

   // code 3 has no screen
   typedef enum logic [1:0] {
      scr_title = 2'd0,
      scr_game  = 2'd1,
      scr_score = 2'd2
   } screen_t;

   // lcd pins
   typedef struct packed {
      logic                   rs;
      logic                   rw;
      logic [`LCD_DATA_W-1:0] data;
   } lcd_bus_t;

   // position of the sequencer
   typedef struct packed {
      phase_t                phase;
      logic [`LCD_CNT_W-1:0] count;
   } lcd_step_t;

endpackage

/* logic/lcd_screen_reg.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_screen_reg (
   input  logic               resetn,
   input  logic               clk,
   input  lcd_pkg::screen_t   screen,
   input  lcd_pkg::lcd_step_t step,
   output lcd_pkg::screen_t   cur_screen
);

   logic frame_start;
   logic screen_valid;

   // last cycle before ph_line1 is entered
   assign frame_start =
      ((step.phase == lcd_pkg::ph_entry_set) &&
       (step.count == `LCD_CNT_W'(`LCD_T_SETUP))) ||
      ((step.phase == lcd_pkg::ph_entry_hold) &&
       (step.count == `LCD_CNT_W'(`LCD_T_ENTRY)));

   assign screen_valid = (screen == lcd_pkg::scr_title) ||
                         (screen == lcd_pkg::scr_game)  ||
                         (screen == lcd_pkg::scr_score);

   always_ff @(posedge resetn or posedge clk) begin
      if (clk) cur_screen <= lcd_pkg::scr_title;
      else if (frame_start && screen_valid) cur_screen <= screen; // code 3 keeps old screen
   end

endmodule

/* logic/lcd_sequencer.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_sequencer (
   input  logic               resetn,
   input  logic               clk,
   output lcd_pkg::lcd_step_t step
);

   lcd_pkg::phase_t       phase;
   lcd_pkg::phase_t       phase_nxt;
   logic [`LCD_CNT_W-1:0] count;
   logic [`LCD_CNT_W-1:0] last_count;

   // per-phase length and successor
   always_comb begin
      case (phase)
         lcd_pkg::ph_powerup: begin
            last_count = `LCD_CNT_W'(`LCD_T_POWERUP);
            phase_nxt  = lcd_pkg::ph_func_set;
         end
         lcd_pkg::ph_func_set: begin
            last_count = `LCD_CNT_W'(`LCD_T_SETUP);
            phase_nxt  = lcd_pkg::ph_disp_on;
         end
         lcd_pkg::ph_disp_on: begin
            last_count = `LCD_CNT_W'(`LCD_T_SETUP);
            phase_nxt  = lcd_pkg::ph_entry_set;
         end
         lcd_pkg::ph_entry_set: begin
            last_count = `LCD_CNT_W'(`LCD_T_SETUP);
            phase_nxt  = lcd_pkg::ph_line1;
         end
         lcd_pkg::ph_line1: begin
            last_count = `LCD_CNT_W'(`LCD_T_LINE);
            phase_nxt  = lcd_pkg::ph_line2;
         end
         lcd_pkg::ph_line2: begin
            last_count = `LCD_CNT_W'(`LCD_T_LINE);
            phase_nxt  = lcd_pkg::ph_home;
         end
         lcd_pkg::ph_home: begin
            last_count = `LCD_CNT_W'(`LCD_T_HOME);
            phase_nxt  = lcd_pkg::ph_entry_hold;
         end
         default: begin
            last_count = `LCD_CNT_W'(`LCD_T_ENTRY);
            phase_nxt  = lcd_pkg::ph_line1; // frame loops back
         end
      endcase
   end

   always_ff @(posedge resetn or posedge clk) begin
      if (clk) begin
         phase <= lcd_pkg::ph_powerup;
         count <= '0;
      end else if (count == last_count) begin
         phase <= phase_nxt;
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   assign step.phase = phase;
   assign step.count = count;

endmodule

/* logic/lcd_text_rom.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_text_rom (
   input  lcd_pkg::screen_t       cur_screen,
   input  lcd_pkg::lcd_step_t     step,
   output logic [`LCD_DATA_W-1:0] char_code
);

   localparam int COL_W  = $clog2(`LCD_COLS);
   localparam int LINE_W = `LCD_DATA_W * `LCD_COLS;

   // leftmost character sits in the top byte
   localparam logic [LINE_W-1:0] TITLE_L1 = "1.Start Game    ";
   localparam logic [LINE_W-1:0] TITLE_L2 = "2.LastGame Score";
   localparam logic [LINE_W-1:0] GAME_L1  = "1.music12.music2";
   localparam logic [LINE_W-1:0] GAME_L2  = "3.music3        ";
   localparam logic [LINE_W-1:0] SCORE_L1 = " Last Game Score";
   localparam logic [LINE_W-1:0] SCORE_L2 = "                ";

   logic              line1_sel;
   logic              in_text;
   logic [COL_W-1:0]  col;
   logic [COL_W-1:0]  rev_col;
   logic [LINE_W-1:0] line_text;

   assign line1_sel = (step.phase == lcd_pkg::ph_line1); // else line 2
   assign in_text   = (step.count != '0) &&
                      (step.count <= `LCD_CNT_W'(`LCD_COLS));

   // count 1 is column 0
   assign col     = step.count[COL_W-1:0] - 1'b1;
   assign rev_col = COL_W'(`LCD_COLS - 1) - col;

   always_comb begin
      case (cur_screen)
         lcd_pkg::scr_game: begin
            line_text = line1_sel ? GAME_L1 : GAME_L2;
         end
         lcd_pkg::scr_score: begin
            line_text = line1_sel ? SCORE_L1 : SCORE_L2;
         end
         default: begin
            line_text = line1_sel ? TITLE_L1 : TITLE_L2;
         end
      endcase
   end

   // trailing columns pad with spaces
   assign char_code = in_text ? line_text[rev_col*`LCD_DATA_W +: `LCD_DATA_W]
                              : `LCD_CHAR_SPACE;

endmodule

/* logic/lcd_top.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_top (
   input  logic              resetn,
   input  logic              clk,
   input  lcd_pkg::screen_t  screen,
   output lcd_pkg::lcd_bus_t lcd,
   output logic              lcd_e
);

   lcd_pkg::lcd_step_t     step;
   lcd_pkg::screen_t       cur_screen;
   logic [`LCD_DATA_W-1:0] char_code;

   lcd_sequencer i_sequencer (
      .resetn (resetn),
      .clk    (clk),
      .step   (step)
   );

   lcd_screen_reg i_screen_reg (
      .resetn     (resetn),
      .clk        (clk),
      .screen     (screen),
      .step       (step),
      .cur_screen (cur_screen)
   );

   lcd_text_rom i_text_rom (
      .cur_screen (cur_screen),
      .step       (step),
      .char_code  (char_code)
   );

   lcd_bus_driver i_bus_driver (
      .resetn    (resetn),
      .clk       (clk),
      .step      (step),
      .char_code (char_code),
      .lcd       (lcd)
   );

   assign lcd_e = resetn; // enable follows the clock

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module lcd_tb -f tb.f -o lcd_sim

sim_out="$(./obj_dir/lcd_sim)"
echo "${sim_out}"

if grep -qx "Simulation PASSED" <<< "${sim_out}"; then
   exit 0
fi
exit 1

/* tb.f */
+incdir+logic
+incdir+tests
logic/lcd_pkg.sv
logic/lcd_sequencer.sv
logic/lcd_screen_reg.sv
logic/lcd_text_rom.sv
logic/lcd_bus_driver.sv
logic/lcd_top.sv
tests/lcd_tb.sv

/* tests/lcd_tb_tasks.svh */
`ifndef LCD_TB_TASKS_SVH
`define LCD_TB_TASKS_SVH

int unsigned      edges;     // rising edges since reset release
lcd_pkg::screen_t frame_scr; // screen shown by the current frame
int unsigned      n_checks;
int unsigned      n_errors;
integer           seed = 86;

localparam lcd_pkg::lcd_bus_t IDLE_BUS = '{rs: 1'b1, rw: 1'b1, data: '0};

function automatic int unsigned phase_len(lcd_pkg::phase_t ph);
   case (ph)
      lcd_pkg::ph_powerup: return `LCD_T_POWERUP + 1;
      lcd_pkg::ph_func_set, lcd_pkg::ph_disp_on, lcd_pkg::ph_entry_set: return `LCD_T_SETUP + 1;
      lcd_pkg::ph_line1, lcd_pkg::ph_line2: return `LCD_T_LINE + 1;
      lcd_pkg::ph_home: return `LCD_T_HOME + 1;
      default: return `LCD_T_ENTRY + 1;
   endcase
endfunction

// phase and count of step n, step 0 right after reset release
function automatic lcd_pkg::phase_t model_step(int unsigned n, output int unsigned cnt);
   lcd_pkg::phase_t ph;
   ph  = lcd_pkg::ph_powerup;
   cnt = n;
   while (cnt >= phase_len(ph)) begin
      cnt = cnt - phase_len(ph);
      ph  = (ph == lcd_pkg::ph_entry_hold) ? lcd_pkg::ph_line1 : ph.next();
   end
   return ph;
endfunction

function automatic bit is_frame_end(int unsigned n);
   lcd_pkg::phase_t ph;
   int unsigned     cnt;
   ph = model_step(n, cnt);
   return (ph == lcd_pkg::ph_entry_set || ph == lcd_pkg::ph_entry_hold) &&
          (cnt == phase_len(ph) - 1);
endfunction

function automatic int unsigned frame_step(int unsigned f);
   return INIT_STEPS + f * FRAME_STEPS;
endfunction

function automatic logic [7:0] text_char(lcd_pkg::screen_t scr, bit line1, int unsigned col);
   string txt;
   if (scr == lcd_pkg::scr_game) begin
      if (line1) txt = "1.music12.music2";
      else txt = "3.music3";
   end else if (scr == lcd_pkg::scr_score) begin
      if (line1) txt = " Last Game Score";
      else txt = "";
   end else begin
      if (line1) txt = "1.Start Game";
      else txt = "2.LastGame Score";
   end
   if (col < txt.len()) return txt[col];
   return `LCD_CHAR_SPACE; // padding past the text
endfunction

function automatic lcd_pkg::lcd_bus_t expected_bus(int unsigned e);
   lcd_pkg::lcd_bus_t b;
   lcd_pkg::phase_t   ph;
   int unsigned       cnt;
   b = '{rs: 1'b0, rw: 1'b0, data: '0};
   if (e == 0) return IDLE_BUS; // nothing clocked out yet
   ph = model_step(e - 1, cnt); // output lags the step by one cycle
   case (ph)
      lcd_pkg::ph_powerup: b = IDLE_BUS;
      lcd_pkg::ph_func_set: b.data = `LCD_CMD_FUNC;
      lcd_pkg::ph_disp_on: b.data = `LCD_CMD_DISP_ON;
      lcd_pkg::ph_home: b.data = `LCD_CMD_HOME;
      lcd_pkg::ph_line1, lcd_pkg::ph_line2: begin
         if (cnt == 0) begin
            b.data = (ph == lcd_pkg::ph_line1) ? `LCD_ADDR_LINE1 : `LCD_ADDR_LINE2;
         end else begin
            b.rs   = 1'b1;
            b.data = text_char(frame_scr, ph == lcd_pkg::ph_line1, cnt - 1);
         end
      end
      default: b.data = `LCD_CMD_ENTRY;
   endcase
   return b;
endfunction

task automatic check_bus(string name, lcd_pkg::lcd_bus_t got, lcd_pkg::lcd_bus_t exp);
   n_checks++;
   if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t ns: %s got rs=%b rw=%b data=0x%h, expected rs=%b rw=%b data=0x%h",
               $time, name, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
   end
endtask

task automatic check_bit(string name, logic got, logic exp);
   n_checks++;
   if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t ns: %s got %b, expected %b", $time, name, got, exp);
   end
endtask

// every falling edge until the model reaches last_edge
task automatic run_checked(int unsigned last_edge);
   while (edges < last_edge) begin
      @(negedge resetn);
      check_bus("lcd", lcd, expected_bus(edges));
   end
endtask

task automatic apply_screen(lcd_pkg::screen_t s);
   @(posedge resetn);
   #DRIVE_DELAY screen = s;
endtask

task automatic test_powerup_idle();
   repeat (RESET_CYCLES) begin
      @(negedge resetn);
      check_bus("lcd", lcd, IDLE_BUS);
   end
   @(posedge resetn);
   #DRIVE_DELAY clk = 1'b0;
   run_checked(`LCD_T_POWERUP + 1);
endtask

task automatic test_setup_commands();
   run_checked(`LCD_T_POWERUP + 2); // 72 cycles after release
   check_bus("lcd", lcd, lcd_pkg::lcd_bus_t'{rs: 1'b0, rw: 1'b0, data: `LCD_CMD_FUNC});
   run_checked(INIT_STEPS);
endtask

task automatic test_title_frame();
   run_checked(frame_step(1) - 100);
endtask

task automatic test_invalid_game();
   apply_screen(lcd_pkg::scr_game);
   run_checked(frame_step(2) - 100);
   apply_screen(lcd_pkg::screen_t'(2'd3));
   run_checked(frame_step(2) + 50);
endtask

task automatic test_random_changes();
   logic [1:0]  code;
   int unsigned at;
   for (int i = 0; i < 6; i++) begin
      at   = frame_step(2) + 1 + i * 7 + $unsigned($random(seed)) % 6; // inside the line phases
      code = 2'($unsigned($random(seed)) % 4);
      run_checked(at);
      apply_screen(lcd_pkg::screen_t'(code));
   end
   run_checked(frame_step(3) + 50);
endtask

task automatic test_invalid_score();
   apply_screen(lcd_pkg::scr_score);
   run_checked(frame_step(4) + 50);
   apply_screen(lcd_pkg::screen_t'(2'd3));
   run_checked(frame_step(N_FRAMES));
endtask

task automatic test_enable_follows_clock();
   repeat (20) begin
      @(posedge resetn);
      #1 check_bit("lcd_e", lcd_e, 1'b1);
      @(negedge resetn);
      #1 check_bit("lcd_e", lcd_e, 1'b0);
      check_bus("lcd", lcd, expected_bus(edges));
   end
endtask

`endif

/* tests/lcd_tb.sv */
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 16;
   localparam int INIT_STEPS   = (`LCD_T_POWERUP + 1) + 3 * (`LCD_T_SETUP + 1);
   localparam int FRAME_STEPS  = 2 * (`LCD_T_LINE + 1) + (`LCD_T_HOME + 1) + (`LCD_T_ENTRY + 1);
   localparam int N_FRAMES     = 6;
   localparam int WATCHDOG_NS  =
      (RESET_CYCLES + INIT_STEPS + N_FRAMES * FRAME_STEPS + 456) * CLK_PERIOD; // ~450 spare

   logic              resetn; // DUT clock
   logic              clk;    // DUT reset, active high
   lcd_pkg::screen_t  screen;
   lcd_pkg::lcd_bus_t lcd;
   logic              lcd_e;

   lcd_top i_lcd_top (
      .resetn (resetn),
      .clk    (clk),
      .screen (screen),
      .lcd    (lcd),
      .lcd_e  (lcd_e)
   );

   `include "lcd_tb_tasks.svh"

   initial begin
      resetn = 1'b0;
      forever #(CLK_PERIOD / 2) resetn = ~resetn;
   end

   // model position, moves on the same edges as the DUT
   always @(posedge resetn or posedge clk) begin
      if (clk) begin
         edges     <= 0;
         frame_scr <= lcd_pkg::scr_title;
      end else begin
         if (is_frame_end(edges) && screen != lcd_pkg::screen_t'(2'd3)) begin
            frame_scr <= screen; // next frame's text
         end
         edges <= edges + 1;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      screen = lcd_pkg::scr_title;
      clk    = 1'b1;
      test_powerup_idle();
      test_setup_commands();
      test_title_frame();
      test_invalid_game();
      test_random_changes();
      test_invalid_score();
      test_enable_follows_clock();
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
